//--- hw/iq_pkg.sv
package iq_pkg;

    // queue and register file sizes
    localparam int IQ_DEPTH = 8;
    localparam int IQ_IDX_W = 3;
    localparam int OCC_W    = IQ_IDX_W + 1;   // occupancy runs 0..IQ_DEPTH
    localparam int PREG_NUM = 64;
    localparam int PREG_W   = 6;
    localparam int ROB_W    = 6;

    // scoreboard lookup layout: two per slot, then four for dispatch
    localparam int LKP_DISP = 2 * IQ_DEPTH;
    localparam int LKP_N    = LKP_DISP + 4;

    typedef logic [IQ_IDX_W-1:0] idx_t;
    typedef logic [OCC_W-1:0]    occ_t;
    typedef logic [PREG_W-1:0]   preg_t;
    typedef logic [ROB_W-1:0]    rob_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // renamed micro-op as it leaves dispatch
    typedef struct packed {
        alu_op_e op;
        preg_t   src0_preg;
        preg_t   src1_preg;
        preg_t   dst_preg;
        logic    dst_we;
        rob_t    rob_tag;
    } uop_t;

    typedef struct packed {
        uop_t       uop;
        logic [1:0] src_rdy;    // bit 0 for src0
    } iq_entry_t;

    // per-slot move control
    typedef struct packed {
        logic enq_en;
        logic enq_sel;      // dispatch port 0 / 1
        logic shift_en;
        logic shift_sel;    // slot i+1 / i+2
    } queue_ctrl_t;

endpackage

//--- hw/iq_entry.sv
`timescale 1ns/1ns

module iq_entry (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  iq_pkg::queue_ctrl_t ctrl,
    input  iq_pkg::iq_entry_t   enq_in_0,
    input  iq_pkg::iq_entry_t   enq_in_1,
    input  iq_pkg::iq_entry_t   above_1,
    input  iq_pkg::iq_entry_t   above_2,
    input  logic [1:0]          src_busy,
    output iq_pkg::iq_entry_t   entry,
    output logic                ready
);

    iq_pkg::iq_entry_t enq_pick;
    iq_pkg::iq_entry_t entry_nxt;

    always_comb begin
        enq_pick = ctrl.enq_sel ? enq_in_1 : enq_in_0;
        if (ctrl.enq_en) begin
            entry_nxt = enq_pick;    // readiness comes with dispatch
        end else if (ctrl.shift_en) begin
            entry_nxt.uop     = ctrl.shift_sel ? above_2.uop : above_1.uop;
            entry_nxt.src_rdy = ~src_busy;
        end else begin
            entry_nxt.uop     = entry.uop;
            entry_nxt.src_rdy = ~src_busy;
        end
    end

    // src_busy already belongs to the uop that lands here
    always_ff @(posedge clk) begin
        entry.uop <= entry_nxt.uop;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entry.src_rdy <= 2'b00;
        end else begin
            entry.src_rdy <= entry_nxt.src_rdy;
        end
    end

    assign ready = &entry.src_rdy;

endmodule

//--- hw/iq_queue_ctrl.sv
`timescale 1ns/1ns

module iq_queue_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                enq_valid_0,
    input  logic                enq_valid_1,
    input  logic                grant_0,
    input  logic                grant_1,
    input  iq_pkg::idx_t        grant_idx_0,
    input  iq_pkg::idx_t        grant_idx_1,
    output iq_pkg::queue_ctrl_t slot_ctrl [iq_pkg::IQ_DEPTH],
    output logic [iq_pkg::IQ_DEPTH-1:0] valid_vec,
    output logic                enq_ready
);

    iq_pkg::occ_t occ;
    iq_pkg::occ_t occ_post;    // count after this cycle's issues
    iq_pkg::occ_t issue_cnt;
    logic         acc_0;
    logic         acc_1;

    // registered count only, same-cycle issue not credited
    assign enq_ready = occ <= iq_pkg::occ_t'(iq_pkg::IQ_DEPTH - 2);

    assign acc_0 = enq_valid_0 && enq_ready;
    assign acc_1 = acc_0 && enq_valid_1;    // port 1 rides with port 0

    assign issue_cnt = iq_pkg::occ_t'(grant_0) + iq_pkg::occ_t'(grant_1);
    assign occ_post  = occ - issue_cnt;

    always_comb begin
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            slot_ctrl[i] = '0;

            // compaction above the issued slots
            if (grant_0 && i >= int'(grant_idx_0)) begin
                slot_ctrl[i].shift_en  = 1'b1;
                slot_ctrl[i].shift_sel = grant_1 && (i >= int'(grant_idx_1) - 1);
            end

            // new uops land just above the survivors
            if (acc_0 && i == int'(occ_post)) begin
                slot_ctrl[i].enq_en  = 1'b1;
                slot_ctrl[i].enq_sel = 1'b0;
            end
            if (acc_1 && i == int'(occ_post) + 1) begin
                slot_ctrl[i].enq_en  = 1'b1;
                slot_ctrl[i].enq_sel = 1'b1;
            end

            valid_vec[i] = i < int'(occ);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occ <= '0;
        end else begin
            occ <= occ_post + iq_pkg::occ_t'(acc_0) + iq_pkg::occ_t'(acc_1);
        end
    end

endmodule

//--- hw/iq_issue_arbiter.sv
`timescale 1ns/1ns

module iq_issue_arbiter (
    input  logic [iq_pkg::IQ_DEPTH-1:0] valid_vec,
    input  logic [iq_pkg::IQ_DEPTH-1:0] ready_vec,
    output logic                        grant_0,
    output logic                        grant_1,
    output iq_pkg::idx_t                grant_idx_0,
    output iq_pkg::idx_t                grant_idx_1
);

    logic [iq_pkg::IQ_DEPTH-1:0] req;

    assign req = valid_vec & ready_vec;

    // low index is old, so scan upward and take the first two
    always_comb begin
        grant_0     = 1'b0;
        grant_1     = 1'b0;
        grant_idx_0 = '0;
        grant_idx_1 = '0;
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            if (req[i]) begin
                if (!grant_0) begin
                    grant_0     = 1'b1;
                    grant_idx_0 = iq_pkg::idx_t'(i);
                end else if (!grant_1) begin
                    grant_1     = 1'b1;
                    grant_idx_1 = iq_pkg::idx_t'(i);
                end
            end
        end
    end

endmodule

//--- hw/busy_table.sv
`timescale 1ns/1ns

module busy_table (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic [1:0]                             set_en,
    input  iq_pkg::preg_t [1:0]                    set_preg,
    input  logic [1:0]                             clr_en,
    input  iq_pkg::preg_t [1:0]                    clr_preg,
    input  iq_pkg::preg_t [iq_pkg::LKP_N-1:0]      lookup_preg,
    output logic [iq_pkg::LKP_N-1:0]               lookup_busy
);

    logic [iq_pkg::PREG_NUM-1:0] busy;
    logic [iq_pkg::PREG_NUM-1:0] busy_nxt;
    logic                        port0_hit;

    always_comb begin
        busy_nxt = busy;
        for (int c = 0; c < 2; c++) begin
            if (clr_en[c]) begin
                busy_nxt[clr_preg[c]] = 1'b0;
            end
        end
        // set wins over a same-edge clear
        for (int s = 0; s < 2; s++) begin
            if (set_en[s]) begin
                busy_nxt[set_preg[s]] = 1'b1;
            end
        end
        busy_nxt[0] = 1'b0;    // p0 never busy
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            busy <= busy_nxt;
        end
    end

    always_comb begin
        port0_hit = 1'b0;
        for (int k = 0; k < iq_pkg::LKP_N; k++) begin
            lookup_busy[k] = busy[lookup_preg[k]];
            // dispatch port 1 sees port 0's destination as already busy
            if (k >= iq_pkg::LKP_DISP + 2) begin
                port0_hit = set_en[0] && (set_preg[0] == lookup_preg[k])
                            && (lookup_preg[k] != '0);
                lookup_busy[k] = lookup_busy[k] || port0_hit;
            end
        end
    end

endmodule

//--- hw/alu_issue_unit.sv
`timescale 1ns/1ns

module alu_issue_unit (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         enq_valid_0,
    input  logic         enq_valid_1,
    input  iq_pkg::uop_t enq_uop_0,
    input  iq_pkg::uop_t enq_uop_1,
    output logic         enq_ready,
    output logic         issue_valid_0,
    output logic         issue_valid_1,
    output iq_pkg::uop_t issue_uop_0,
    output iq_pkg::uop_t issue_uop_1
);

    iq_pkg::queue_ctrl_t slot_ctrl [iq_pkg::IQ_DEPTH];
    iq_pkg::iq_entry_t   slot_q    [iq_pkg::IQ_DEPTH+2];    // top two are padding
    logic [1:0]          slot_busy [iq_pkg::IQ_DEPTH+2];
    logic [1:0]          src_busy  [iq_pkg::IQ_DEPTH];
    logic [iq_pkg::IQ_DEPTH-1:0] valid_vec;
    logic [iq_pkg::IQ_DEPTH-1:0] ready_vec;

    logic                grant_0;
    logic                grant_1;
    iq_pkg::idx_t        grant_idx_0;
    iq_pkg::idx_t        grant_idx_1;

    iq_pkg::preg_t [iq_pkg::LKP_N-1:0] lookup_preg;
    logic [iq_pkg::LKP_N-1:0]          lookup_busy;
    logic [1:0]          set_en;
    logic [1:0]          clr_en;
    iq_pkg::iq_entry_t   new_0;
    iq_pkg::iq_entry_t   new_1;

    iq_queue_ctrl u_iq_queue_ctrl (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .enq_valid_0 (enq_valid_0),
        .enq_valid_1 (enq_valid_1),
        .grant_0     (grant_0),
        .grant_1     (grant_1),
        .grant_idx_0 (grant_idx_0),
        .grant_idx_1 (grant_idx_1),
        .slot_ctrl   (slot_ctrl),
        .valid_vec   (valid_vec),
        .enq_ready   (enq_ready)
    );

    // new entries start with readiness as of the dispatch cycle
    assign new_0 = {enq_uop_0, ~lookup_busy[iq_pkg::LKP_DISP+1:iq_pkg::LKP_DISP]};
    assign new_1 = {enq_uop_1, ~lookup_busy[iq_pkg::LKP_DISP+3:iq_pkg::LKP_DISP+2]};

    assign slot_q[iq_pkg::IQ_DEPTH]      = '0;
    assign slot_q[iq_pkg::IQ_DEPTH+1]    = '0;
    assign slot_busy[iq_pkg::IQ_DEPTH]   = 2'b00;
    assign slot_busy[iq_pkg::IQ_DEPTH+1] = 2'b00;

    for (genvar g = 0; g < iq_pkg::IQ_DEPTH; g++) begin : g_slot
        assign lookup_preg[2*g]   = slot_q[g].uop.src0_preg;
        assign lookup_preg[2*g+1] = slot_q[g].uop.src1_preg;
        assign slot_busy[g]       = lookup_busy[2*g+1:2*g];

        // busy bits follow the uop that moves into this slot
        assign src_busy[g] = !slot_ctrl[g].shift_en ? slot_busy[g]   :
                             slot_ctrl[g].shift_sel ? slot_busy[g+2] : slot_busy[g+1];

        iq_entry u_iq_entry (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .ctrl     (slot_ctrl[g]),
            .enq_in_0 (new_0),
            .enq_in_1 (new_1),
            .above_1  (slot_q[g+1]),
            .above_2  (slot_q[g+2]),
            .src_busy (src_busy[g]),
            .entry    (slot_q[g]),
            .ready    (ready_vec[g])
        );
    end

    iq_issue_arbiter u_iq_issue_arbiter (
        .valid_vec   (valid_vec),
        .ready_vec   (ready_vec),
        .grant_0     (grant_0),
        .grant_1     (grant_1),
        .grant_idx_0 (grant_idx_0),
        .grant_idx_1 (grant_idx_1)
    );

    assign issue_valid_0 = grant_0;
    assign issue_valid_1 = grant_1;
    assign issue_uop_0   = slot_q[grant_idx_0].uop;
    assign issue_uop_1   = slot_q[grant_idx_1].uop;

    assign lookup_preg[iq_pkg::LKP_DISP]   = enq_uop_0.src0_preg;
    assign lookup_preg[iq_pkg::LKP_DISP+1] = enq_uop_0.src1_preg;
    assign lookup_preg[iq_pkg::LKP_DISP+2] = enq_uop_1.src0_preg;
    assign lookup_preg[iq_pkg::LKP_DISP+3] = enq_uop_1.src1_preg;

    assign set_en[0] = enq_valid_0 && enq_ready && enq_uop_0.dst_we;
    assign set_en[1] = enq_valid_0 && enq_valid_1 && enq_ready && enq_uop_1.dst_we;
    assign clr_en[0] = issue_valid_0 && issue_uop_0.dst_we;    // wakes dependents
    assign clr_en[1] = issue_valid_1 && issue_uop_1.dst_we;

    busy_table u_busy_table (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .set_en      (set_en),
        .set_preg    ({enq_uop_1.dst_preg, enq_uop_0.dst_preg}),
        .clr_en      (clr_en),
        .clr_preg    ({issue_uop_1.dst_preg, issue_uop_0.dst_preg}),
        .lookup_preg (lookup_preg),
        .lookup_busy (lookup_busy)
    );

endmodule

//--- tb/tb_iq_model.svh
`ifndef TB_IQ_MODEL_SVH
`define TB_IQ_MODEL_SVH

// one outstanding uop and the cycle it was accepted in
typedef struct packed {
    iq_pkg::uop_t uop;
    int           enq_cyc;
} model_ent_t;

model_ent_t mq[$];                        // oldest first
bit         pending   [iq_pkg::PREG_NUM]; // producer accepted, not yet issued
int         issued_at [iq_pkg::PREG_NUM]; // cycle the last producer issued

function automatic void clear_model();
    mq.delete();
    for (int p = 0; p < iq_pkg::PREG_NUM; p++) begin
        pending[p]   = 1'b0;
        issued_at[p] = -100;
    end
endfunction

// register usable in cycle c under the max(e+1, t+2) rule
function automatic bit src_clear(input iq_pkg::preg_t p, input int c);
    if (p == '0) return 1'b1;
    if (pending[p]) return 1'b0;
    return c >= issued_at[p] + 2;
endfunction

function automatic bit entry_issuable(input int i, input int c);
    return (c >= mq[i].enq_cyc + 1) && src_clear(mq[i].uop.src0_preg, c)
           && src_clear(mq[i].uop.src1_preg, c);
endfunction

// a register that an outstanding uop still reads or writes
function automatic bit preg_in_use(input iq_pkg::preg_t p);
    foreach (mq[i]) begin
        if (mq[i].uop.src0_preg == p || mq[i].uop.src1_preg == p) return 1'b1;
        if (mq[i].uop.dst_we && mq[i].uop.dst_preg == p) return 1'b1;
    end
    return 1'b0;
endfunction

function automatic void retire_entry(input int i, input int c);
    if (mq[i].uop.dst_we) begin
        pending[mq[i].uop.dst_preg]   = 1'b0;
        issued_at[mq[i].uop.dst_preg] = c;
    end
    mq.delete(i);
endfunction

function automatic void accept_uop(input iq_pkg::uop_t u, input int c);
    model_ent_t ent;
    ent.uop     = u;
    ent.enq_cyc = c;
    mq.push_back(ent);
    if (u.dst_we && u.dst_preg != '0) pending[u.dst_preg] = 1'b1;
endfunction

`endif

//--- tb/tb_alu_issue_unit.sv
`timescale 1ns/1ns

module tb_alu_issue_unit;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 4;
    localparam int DRAIN      = 24;
    localparam int TOTAL_CYCLES = RST_CYCLES + 2 + 6 + (60 + DRAIN) + (150 + DRAIN)
                                  + (150 + DRAIN) + (40 + DRAIN) + (14 + DRAIN);

    logic         clk = 1'b0;
    logic         rst;
    logic         flush;
    logic         enq_valid_0;
    logic         enq_valid_1;
    iq_pkg::uop_t enq_uop_0;
    iq_pkg::uop_t enq_uop_1;
    logic         enq_ready;
    logic         issue_valid_0;
    logic         issue_valid_1;
    iq_pkg::uop_t issue_uop_0;
    iq_pkg::uop_t issue_uop_1;

    logic [31:0]   seed = 32'h1816;
    int            cyc;
    int            errors;
    int            checks;
    int            tests;
    int            test_base;
    int            drop_cnt;
    iq_pkg::rob_t  next_tag;
    iq_pkg::preg_t chain_reg;
    bit            dropped  [64];
    bit            preflush [64];
    bit            watch_on;
    iq_pkg::rob_t  watch_tag;
    int            watch_cyc;

    `include "tb_iq_model.svh"

    alu_issue_unit u_alu_issue_unit (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .enq_valid_0   (enq_valid_0),
        .enq_valid_1   (enq_valid_1),
        .enq_uop_0     (enq_uop_0),
        .enq_uop_1     (enq_uop_1),
        .enq_ready     (enq_ready),
        .issue_valid_0 (issue_valid_0),
        .issue_valid_1 (issue_valid_1),
        .issue_uop_0   (issue_uop_0),
        .issue_uop_1   (issue_uop_1)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("ERROR %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // mode 0 independent, 1 small register pool, 2 dependence chain
    task automatic make_uop(input int mode, input iq_pkg::uop_t older, input bit second,
                            output iq_pkg::uop_t u);
        logic [31:0] r;
        int          pool;
        r    = lcg_next();
        pool = (mode == 1) ? 12 : 64;
        u    = '0;
        u.op       = iq_pkg::alu_op_e'(r[18:16]);
        u.rob_tag  = next_tag;
        next_tag   = iq_pkg::rob_t'(next_tag + 1);
        u.dst_we   = (mode == 2) || r[19];
        u.dst_preg = iq_pkg::preg_t'(1 + (r[31:20] % (pool - 1)));
        if (mode == 1) begin
            u.src0_preg = iq_pkg::preg_t'(lcg_next() % pool);
            u.src1_preg = iq_pkg::preg_t'(lcg_next() % pool);
        end else if (mode == 2) begin
            u.src0_preg = chain_reg;
        end
        // no reuse of a register still in flight, as rename would guarantee
        if (preg_in_use(u.dst_preg)) u.dst_we = 1'b0;
        if (u.dst_preg == u.src0_preg || u.dst_preg == u.src1_preg) u.dst_we = 1'b0;
        if (second && (u.dst_preg == older.dst_preg || u.dst_preg == older.src0_preg
                       || u.dst_preg == older.src1_preg)) u.dst_we = 1'b0;
        if (mode == 2 && u.dst_we) chain_reg = u.dst_preg;
    endtask

    task automatic check_cycle();
        int e0;
        int e1;
        bit rdy_rule;
        e0 = -1;
        e1 = -1;
        for (int i = 0; i < mq.size(); i++) begin
            if (entry_issuable(i, cyc)) begin
                if (e0 < 0) e0 = i;
                else if (e1 < 0) e1 = i;
            end
        end
        rdy_rule = mq.size() <= iq_pkg::IQ_DEPTH - 2;
        check_true(enq_ready == rdy_rule, "enq_ready differs from the occupancy rule");
        check_true(issue_valid_0 == (e0 >= 0), "issue_valid_0 differs from model");
        check_true(issue_valid_1 == (e1 >= 0), "issue_valid_1 differs from model");
        check_true(!(issue_valid_1 && !issue_valid_0), "issue_valid_1 without issue_valid_0");
        if (issue_valid_0 && e0 >= 0)
            check_true(issue_uop_0 == mq[e0].uop, "issue_uop_0 is not the oldest issuable");
        if (issue_valid_1 && e1 >= 0)
            check_true(issue_uop_1 == mq[e1].uop, "issue_uop_1 is not the second oldest");
        if (issue_valid_0)
            check_true(!dropped[issue_uop_0.rob_tag] && !preflush[issue_uop_0.rob_tag],
                       "issued a uop that was dropped or flushed");
        if (issue_valid_1)
            check_true(!dropped[issue_uop_1.rob_tag] && !preflush[issue_uop_1.rob_tag],
                       "issued a uop that was dropped or flushed");
        if (watch_on && cyc == watch_cyc + 1) begin
            check_true(issue_valid_0 && issue_uop_0.rob_tag == watch_tag,
                       "post-flush uop did not issue one cycle after enqueue");
            watch_on = 1'b0;
        end
        if (e1 >= 0) retire_entry(e1, cyc);    // higher index first
        if (e0 >= 0) retire_entry(e0, cyc);
        if (flush) begin
            foreach (mq[i]) preflush[mq[i].uop.rob_tag] = 1'b1;
            clear_model();
        end else if (enq_valid_0) begin
            if (rdy_rule) begin
                accept_uop(enq_uop_0, cyc);
                dropped[enq_uop_0.rob_tag]  = 1'b0;
                preflush[enq_uop_0.rob_tag] = 1'b0;
                if (enq_valid_1) begin
                    accept_uop(enq_uop_1, cyc);
                    dropped[enq_uop_1.rob_tag]  = 1'b0;
                    preflush[enq_uop_1.rob_tag] = 1'b0;
                end
            end else begin
                drop_cnt++;
                dropped[enq_uop_0.rob_tag] = 1'b1;
                if (enq_valid_1) dropped[enq_uop_1.rob_tag] = 1'b1;
            end
        end
    endtask

    task automatic drive_cycle(input bit v0, input bit v1, input iq_pkg::uop_t u0,
                               input iq_pkg::uop_t u1, input bit fl);
        @(posedge clk);
        cyc++;
        enq_valid_0 <= v0;
        enq_valid_1 <= v1;
        enq_uop_0   <= u0;
        enq_uop_1   <= u1;
        flush       <= fl;
        @(negedge clk);
        check_cycle();
    endtask

    task automatic random_cycles(input int n, input int mode, input int gap_pct,
                                 input int drain);
        logic [31:0]  r;
        iq_pkg::uop_t u0;
        iq_pkg::uop_t u1;
        for (int k = 0; k < n; k++) begin
            r  = lcg_next();
            u1 = '0;
            if ((r[31:16] % 100) < gap_pct) begin
                drive_cycle(1'b0, 1'b0, '0, '0, 1'b0);
            end else begin
                make_uop(mode, '0, 1'b0, u0);
                if (r[9] || mode == 2) make_uop(mode, u0, 1'b1, u1);
                drive_cycle(1'b1, r[9] || mode == 2, u0, u1, 1'b0);
            end
        end
        repeat (drain) drive_cycle(1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic finish_test(input string name);
        check_true(mq.size() == 0, "accepted uops never issued");
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        iq_pkg::uop_t  u;
        iq_pkg::preg_t busy_reg;
        rst = 1'b1;
        flush = 1'b0;
        enq_valid_0 = 1'b0;
        enq_valid_1 = 1'b0;
        enq_uop_0 = '0;
        enq_uop_1 = '0;
        clear_model();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_true(!issue_valid_0 && !issue_valid_1 && enq_ready, "wrong state after reset");
        repeat (6) drive_cycle(1'b0, 1'b0, '0, '0, 1'b0);
        finish_test("reset idle");
        random_cycles(60, 0, 40, DRAIN);
        finish_test("independent uops");
        random_cycles(150, 1, 30, DRAIN);
        finish_test("oldest ready order");
        random_cycles(150, 1, 5, DRAIN);
        finish_test("dependence timing");
        drop_cnt = 0;
        random_cycles(40, 2, 0, DRAIN);
        check_true(drop_cnt > 0, "queue never filled up under back-pressure");
        finish_test("back-pressure");
        random_cycles(12, 2, 0, 0);
        // a producer that cannot issue in the flush cycle keeps its register busy
        busy_reg = '0;
        foreach (mq[i]) begin
            if (mq[i].uop.dst_we && !entry_issuable(i, cyc + 1)) begin
                busy_reg = mq[i].uop.dst_preg;
            end
        end
        check_true(busy_reg != '0, "no busy register left when the flush came");
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b1);
        make_uop(0, '0, 1'b0, u);
        u.src0_preg = busy_reg;
        if (u.dst_preg == busy_reg) u.dst_we = 1'b0;
        watch_on  = 1'b1;
        watch_tag = u.rob_tag;
        watch_cyc = cyc + 1;
        drive_cycle(1'b1, 1'b0, u, '0, 1'b0);
        check_true(enq_ready, "enq_ready low after flush");
        repeat (DRAIN) drive_cycle(1'b0, 1'b0, '0, '0, 1'b0);
        check_true(!watch_on, "post-flush uop was never checked");
        finish_test("flush");
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("timeout, the run did not finish in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tb
hw/iq_pkg.sv
hw/iq_entry.sv
hw/iq_queue_ctrl.sv
hw/iq_issue_arbiter.sv
hw/busy_table.sv
hw/alu_issue_unit.sv
tb/tb_alu_issue_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu_issue_unit
DUT_TOP   ?= alu_issue_unit
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "simulation failed" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
